// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := flags_rename_tb
FILELIST  := flags_rename.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
RUN_ARGS  := +verilator+error+limit+100
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	@out="$$($(BIN) $(RUN_ARGS))"; echo "$$out"; echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: flags_rename.f
rtl/flags_rename_pkg.sv
rtl/flag_write_arbiter.sv
rtl/flags_entry_buf.sv
rtl/bundle_bypass.sv
rtl/flags_read_stage.sv
rtl/flags_rename_top.sv
testbench/flags_rename_asserts.sv
testbench/flags_rename_tb.sv

// File: rtl/bundle_bypass.sv
// In-bundle dependency lookup that finds the nearest earlier lane writing each lane's read index.
`timescale 1ns/1ps
`default_nettype none

module bundle_bypass
  import flags_rename_pkg::*;
#(
  parameter int N_LANES = 4
) (
  input  reg_idx_t [N_LANES-1:0]  read_idx,
  input  reg_idx_t [N_LANES-1:0]  lane_dst_idx,
  input  logic [N_LANES-1:0]      lane_wen,
  input  rob_addr_t [N_LANES-1:0] lane_rob,
  input  fn_code_t [N_LANES-1:0]  lane_fn,
  output logic [N_LANES-1:0]      hit,
  output rob_addr_t [N_LANES-1:0] hit_rob,
  output fn_code_t [N_LANES-1:0]  hit_fn
);

  // Scanning upward leaves the closest older producer in place.
  always_comb
  begin
    hit = '0;
    hit_rob = '0;
    hit_fn = '0;
    for (int k = 1; k < N_LANES; k++)
    begin
      for (int j = 0; j < k; j++)
      begin
        if (lane_wen[j] && lane_dst_idx[j] == read_idx[k])
        begin
          hit[k] = 1'b1;
          hit_rob[k] = lane_rob[j];
          hit_fn[k] = lane_fn[j];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/flag_write_arbiter.sv
// Last-lane-wins arbiter that selects one flag-writing lane of a rename bundle for the flags buffer.
`timescale 1ns/1ps
`default_nettype none

module flag_write_arbiter
  import flags_rename_pkg::*;
#(
  parameter int N_LANES = 4
) (
  input  logic [N_LANES-1:0]      lane_wen,
  input  rob_addr_t [N_LANES-1:0] lane_rob,
  input  fn_code_t [N_LANES-1:0]  lane_fn,
  output logic                    any_write,
  output rob_addr_t               sel_rob,
  output fn_code_t                sel_fn
);

  // Lanes are in program order, so the highest active lane holds the youngest flags.
  always_comb
  begin
    any_write = 1'b0;
    sel_rob = '0;
    sel_fn = RESET_FUNIT; // Idle value matches the reset code of the buffer.
    for (int i = 0; i < N_LANES; i++)
    begin
      if (lane_wen[i])
      begin
        any_write = 1'b1;
        sel_rob = lane_rob[i]; // A later lane overrides an earlier one.
        sel_fn = lane_fn[i];
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/flags_entry_buf.sv
// Per-thread flags producer entries with new-write and retirement update; instanced by the top.
`timescale 1ns/1ps
`default_nettype none

module flags_entry_buf
  import flags_rename_pkg::*;
#(
  parameter int N_RET = 3
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  any_write,
  input  rob_addr_t             sel_rob,
  input  fn_code_t              sel_fn,
  input  logic                  write_thread,
  input  rob_addr_t [N_RET-1:0] ret_addr,
  input  logic [N_RET-1:0]      ret_wen,
  input  logic                  retire_all,
  input  logic                  ret_thread,
  output rob_addr_t             buf_rob,
  output fn_code_t              buf_fn,
  output logic                  buf_retired
);

  rob_addr_t rob_q [0:1];
  fn_code_t fn_q [0:1];
  logic [1:0] retired_q;

  logic [1:0] ret_hit;
  logic [1:0] wr_hit;
  logic [1:0] ret_set;

  // Any active retire port that names the stored producer retires it.
  always_comb
  begin
    ret_hit = '0;
    for (int t = 0; t < 2; t++)
    begin
      for (int p = 0; p < N_RET; p++)
      begin
        if (ret_wen[p] && ret_addr[p] == rob_q[t])
        begin
          ret_hit[t] = 1'b1;
        end
      end
    end
  end

  assign wr_hit[0] = any_write & ~write_thread;
  assign wr_hit[1] = any_write & write_thread;

  // A new producer in the same cycle is younger, so it stays unretired.
  assign ret_set[0] = (ret_hit[0] | retire_all) & ~ret_thread & ~wr_hit[0];
  assign ret_set[1] = (ret_hit[1] | retire_all) & ret_thread & ~wr_hit[1];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int t = 0; t < 2; t++)
      begin
        rob_q[t] <= '0;
        fn_q[t] <= RESET_FUNIT;
        retired_q[t] <= 1'b1; // Architectural flags are committed at reset.
      end
    end
    else
    begin
      for (int t = 0; t < 2; t++)
      begin
        if (wr_hit[t])
        begin
          rob_q[t] <= sel_rob;
          fn_q[t] <= sel_fn;
          retired_q[t] <= 1'b0;
        end
        else if (ret_set[t])
        begin
          retired_q[t] <= 1'b1;
        end
      end
    end
  end

  assign buf_rob = rob_q[write_thread]; // Reads and writes share the bundle thread.
  assign buf_fn = fn_q[write_thread];
  assign buf_retired = retired_q[write_thread];

endmodule

`default_nettype wire

// File: rtl/flags_read_stage.sv
// Registers the bundle's read indices and thread, then forms each lane's flags read result.
`timescale 1ns/1ps
`default_nettype none

module flags_read_stage
  import flags_rename_pkg::*;
#(
  parameter int N_LANES = 4
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    read_en,
  input  logic                    thread,
  input  reg_idx_t [N_LANES-1:0]  lane_read_idx,
  input  rob_addr_t               buf_rob,
  input  fn_code_t                buf_fn,
  input  logic                    buf_retired,
  input  logic [N_LANES-1:0]      hit,
  input  rob_addr_t [N_LANES-1:0] hit_rob,
  input  fn_code_t [N_LANES-1:0]  hit_fn,
  output reg_idx_t [N_LANES-1:0]  read_idx,
  output logic                    bundle_thread,
  output rob_addr_t [N_LANES-1:0] lane_data,
  output fn_code_t [N_LANES-1:0]  lane_fn_out,
  output logic [N_LANES-1:0]      lane_retired
);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      read_idx <= '0;
      bundle_thread <= 1'b0;
    end
    else if (read_en)
    begin
      read_idx <= lane_read_idx;
      bundle_thread <= thread;
    end
  end

  always_comb
  begin
    for (int k = 0; k < N_LANES; k++)
    begin
      if (read_idx[k] == FLAGS_IDX)
      begin
        lane_data[k] = buf_rob;
        lane_fn_out[k] = buf_fn;
        lane_retired[k] = buf_retired;
      end
      else if (read_idx[k] == RETIRED_IDX)
      begin
        lane_data[k] = buf_rob;
        lane_fn_out[k] = buf_fn;
        lane_retired[k] = 1'b1;
      end
      else
      begin
        // Ordinary indices only depend on older lanes of this bundle.
        lane_data[k] = hit[k] ? hit_rob[k] : '0;
        lane_fn_out[k] = hit[k] ? hit_fn[k] : '0;
        lane_retired[k] = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/flags_rename_pkg.sv
// Shared widths, types and special register indices of the flags rename table; import it where needed.
`default_nettype none

package flags_rename_pkg;

  localparam int unsigned ROB_ADDR_W = 6;
  localparam int unsigned FN_W = 10;
  localparam int unsigned REG_IDX_W = 4;

  typedef logic [ROB_ADDR_W-1:0] rob_addr_t;
  typedef logic [FN_W-1:0] fn_code_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  // Architectural index of the flags register.
  localparam reg_idx_t FLAGS_IDX = reg_idx_t'(14);

  // Reads the flags producer as if it had already retired.
  localparam reg_idx_t RETIRED_IDX = reg_idx_t'(13);

  // Functional-unit code held after reset and driven when no lane writes.
  localparam fn_code_t RESET_FUNIT = fn_code_t'(9);

endpackage

`default_nettype wire

// File: rtl/flags_rename_top.sv
// Flags rename table top level that wires the arbiter, buffer, bypass and read stage together.
`timescale 1ns/1ps
`default_nettype none

module flags_rename_top
  import flags_rename_pkg::*;
#(
  parameter int N_LANES = 4,
  parameter int N_RET = 3
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    read_en,
  input  logic                    thread,
  input  reg_idx_t [N_LANES-1:0]  lane_read_idx,
  input  logic [N_LANES-1:0]      lane_wen,
  input  reg_idx_t [N_LANES-1:0]  lane_dst_idx,
  input  rob_addr_t [N_LANES-1:0] lane_rob,
  input  fn_code_t [N_LANES-1:0]  lane_fn,
  input  rob_addr_t [N_RET-1:0]   ret_addr,
  input  logic [N_RET-1:0]        ret_wen,
  input  logic                    retire_all,
  input  logic                    ret_thread,
  output rob_addr_t [N_LANES-1:0] lane_data,
  output fn_code_t [N_LANES-1:0]  lane_fn_out,
  output logic [N_LANES-1:0]      lane_retired
);

  logic any_write;
  rob_addr_t sel_rob;
  fn_code_t sel_fn;

  rob_addr_t buf_rob;
  fn_code_t buf_fn;
  logic buf_retired;

  reg_idx_t [N_LANES-1:0] read_idx;
  logic bundle_thread;

  logic [N_LANES-1:0] hit;
  rob_addr_t [N_LANES-1:0] hit_rob;
  fn_code_t [N_LANES-1:0] hit_fn;

  flag_write_arbiter #(
    .N_LANES (N_LANES)
  ) i_flag_write_arbiter (
    .lane_wen  (lane_wen),
    .lane_rob  (lane_rob),
    .lane_fn   (lane_fn),
    .any_write (any_write),
    .sel_rob   (sel_rob),
    .sel_fn    (sel_fn)
  );

  // Writes land in the entry of the bundle currently held by the read stage.
  flags_entry_buf #(
    .N_RET (N_RET)
  ) i_flags_entry_buf (
    .clk          (clk),
    .rst          (rst),
    .any_write    (any_write),
    .sel_rob      (sel_rob),
    .sel_fn       (sel_fn),
    .write_thread (bundle_thread),
    .ret_addr     (ret_addr),
    .ret_wen      (ret_wen),
    .retire_all   (retire_all),
    .ret_thread   (ret_thread),
    .buf_rob      (buf_rob),
    .buf_fn       (buf_fn),
    .buf_retired  (buf_retired)
  );

  bundle_bypass #(
    .N_LANES (N_LANES)
  ) i_bundle_bypass (
    .read_idx     (read_idx),
    .lane_dst_idx (lane_dst_idx),
    .lane_wen     (lane_wen),
    .lane_rob     (lane_rob),
    .lane_fn      (lane_fn),
    .hit          (hit),
    .hit_rob      (hit_rob),
    .hit_fn       (hit_fn)
  );

  flags_read_stage #(
    .N_LANES (N_LANES)
  ) i_flags_read_stage (
    .clk           (clk),
    .rst           (rst),
    .read_en       (read_en),
    .thread        (thread),
    .lane_read_idx (lane_read_idx),
    .buf_rob       (buf_rob),
    .buf_fn        (buf_fn),
    .buf_retired   (buf_retired),
    .hit           (hit),
    .hit_rob       (hit_rob),
    .hit_fn        (hit_fn),
    .read_idx      (read_idx),
    .bundle_thread (bundle_thread),
    .lane_data     (lane_data),
    .lane_fn_out   (lane_fn_out),
    .lane_retired  (lane_retired)
  );

endmodule

`default_nettype wire

// File: testbench/flags_rename_asserts.sv
// Concurrent checks on the flags entry buffer; bound into the buffer below.
`timescale 1ns/1ps
`default_nettype none

module flags_rename_asserts
  import flags_rename_pkg::*;
(
  input logic       clk,
  input logic       rst,
  input logic       any_write,
  input logic       write_thread,
  input rob_addr_t  buf_rob,
  input fn_code_t   buf_fn,
  input logic       buf_retired,
  input logic [1:0] retired_q
);

  int fail_count = 0;

  // Both producers count as committed straight after reset.
  reset_retired: assert property (@(posedge clk) rst |=> buf_retired)
  else
  begin
    $error("buf_retired is low after reset");
    fail_count++;
  end

  write_clears: assert property (@(posedge clk) disable iff (rst)
    any_write |=> !retired_q[$past(write_thread)])
  else
  begin
    $error("a new flags producer did not clear its retired bit");
    fail_count++;
  end

  known_outputs: assert property (@(posedge clk) disable iff (rst)
    !$isunknown({buf_rob, buf_fn, buf_retired}))
  else
  begin
    $error("buffer outputs are unknown after reset");
    fail_count++;
  end

endmodule

bind flags_entry_buf flags_rename_asserts i_flags_rename_asserts (.*);

`default_nettype wire

// File: testbench/flags_rename_tb.sv
// Testbench that drives directed and random bundles and checks each lane against a model.
`timescale 1ns/1ps
`default_nettype none

module flags_rename_tb
  import flags_rename_pkg::*;
();

  localparam int N_LANES = 4;
  localparam int N_RET = 3;
  localparam int N_CYCLES = 600;

  logic clk, rst, read_en, thread, retire_all, ret_thread;
  reg_idx_t [N_LANES-1:0] lane_read_idx, lane_dst_idx;
  logic [N_LANES-1:0] lane_wen, lane_retired;
  rob_addr_t [N_LANES-1:0] lane_rob, lane_data;
  fn_code_t [N_LANES-1:0] lane_fn, lane_fn_out;
  rob_addr_t [N_RET-1:0] ret_addr;
  logic [N_RET-1:0] ret_wen;

  rob_addr_t m_rob [0:1]; // Model of the two producer entries.
  fn_code_t m_fn [0:1];
  logic [1:0] m_ret;
  reg_idx_t [N_LANES-1:0] m_idx; // Model of the registered bundle.
  logic m_thread;
  logic [31:0] rng = 32'd39;

  flags_rename_top #(.N_LANES(N_LANES), .N_RET(N_RET)) i_flags_rename_top (.*);

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  task automatic fail_now();
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  task automatic clear_inputs();
    read_en = 1'b0;
    thread = 1'b0;
    lane_read_idx = '0;
    lane_wen = '0;
    lane_dst_idx = '0;
    lane_rob = '0;
    lane_fn = '0;
    ret_addr = '0;
    ret_wen = '0;
    retire_all = 1'b0;
    ret_thread = 1'b0;
  endtask

  // Applies one rising edge to the model, then steps to the drive point.
  task automatic tick();
    logic wr;
    logic hit;
    rob_addr_t w_rob;
    fn_code_t w_fn;
    @(posedge clk);
    if (rst)
    begin
      m_rob = '{default: '0};
      m_fn = '{default: RESET_FUNIT};
      m_ret = 2'b11;
      m_idx = '0;
      m_thread = 1'b0;
    end
    else
    begin
      wr = 1'b0;
      w_rob = '0;
      w_fn = '0;
      for (int i = 0; i < N_LANES; i++)
      begin
        if (lane_wen[i])
        begin
          wr = 1'b1; // The youngest writing lane is kept.
          w_rob = lane_rob[i];
          w_fn = lane_fn[i];
        end
      end
      for (int t = 0; t < 2; t++)
      begin
        hit = retire_all;
        for (int p = 0; p < N_RET; p++)
          if (ret_wen[p] && ret_addr[p] == m_rob[t])
            hit = 1'b1;
        if (wr && m_thread == 1'(t))
        begin
          m_rob[t] = w_rob;
          m_fn[t] = w_fn;
          m_ret[t] = 1'b0;
        end
        else if (hit && ret_thread == 1'(t))
          m_ret[t] = 1'b1;
      end
      if (read_en)
      begin
        m_idx = lane_read_idx;
        m_thread = thread;
      end
    end
    #1;
  endtask

  // Read indices lean on low registers and the two flag indices so that every case is hit.
  task automatic drive_random();
    logic [31:0] r;
    for (int k = 0; k < N_LANES; k++)
    begin
      r = xorshift32();
      lane_read_idx[k] = r[2] ? (r[0] ? FLAGS_IDX : RETIRED_IDX) : {2'b00, r[1:0]};
      lane_dst_idx[k] = {2'b00, r[4:3]};
      lane_wen[k] = (r[6:5] == 2'b00);
      lane_rob[k] = r[12:7];
      lane_fn[k] = r[22:13];
    end
    r = xorshift32();
    read_en = r[0] | r[1];
    thread = r[2];
    ret_thread = r[3];
    retire_all = (r[6:4] == 3'd0);
    for (int p = 0; p < N_RET; p++)
    begin
      ret_wen[p] = r[7 + p];
      ret_addr[p] = r[10 + p] ? m_rob[ret_thread] : r[13 + 4*p +: 6]; // Half aim at the producer.
    end
  endtask

  task automatic check_lanes(input string name);
    rob_addr_t e_rob;
    fn_code_t e_fn;
    logic e_ret;
    @(negedge clk);
    for (int k = 0; k < N_LANES; k++)
    begin
      e_rob = '0;
      e_fn = '0;
      e_ret = 1'b0;
      if (m_idx[k] == FLAGS_IDX || m_idx[k] == RETIRED_IDX)
      begin
        e_rob = m_rob[m_thread];
        e_fn = m_fn[m_thread];
        e_ret = (m_idx[k] == RETIRED_IDX) | m_ret[m_thread];
      end
      else
      begin
        for (int j = 0; j < k; j++)
        begin
          if (lane_wen[j] && lane_dst_idx[j] == m_idx[k])
          begin
            e_rob = lane_rob[j]; // Nearest older producer ends up last.
            e_fn = lane_fn[j];
          end
        end
      end
      assert ({lane_data[k], lane_fn_out[k], lane_retired[k]} === {e_rob, e_fn, e_ret})
      else
      begin
        $display(
          "ERR %s lane %0d: expected rob %0d fn %0d ret %0b, actual rob %0d fn %0d ret %0b",
          name, k, e_rob, e_fn, e_ret, lane_data[k], lane_fn_out[k], lane_retired[k]);
        fail_now();
      end
    end
    assert (i_flags_rename_top.i_flags_entry_buf.i_flags_rename_asserts.fail_count == 0)
    else
    begin
      $display("A concurrent check on the flags buffer failed during %s.", name);
      fail_now();
    end
  endtask

  initial
  begin
    int wait_cycles;
    rst = 1'b1;
    clear_inputs();
    repeat (5) tick();
    rst = 1'b0;
    wait_cycles = 0;
    while ($isunknown({lane_data, lane_fn_out, lane_retired}))
    begin
      tick();
      wait_cycles++;
      if (wait_cycles > 10)
      begin
        $display("The lane outputs stayed unknown after reset was released.");
        fail_now();
      end
    end
    for (int t = 0; t < 2; t++)
    begin
      tick();
      read_en = 1'b1;
      thread = 1'(t);
      lane_read_idx = {N_LANES{FLAGS_IDX}};
      check_lanes("reset_read");
      tick();
      read_en = 1'b0;
      check_lanes("reset_read");
    end
    for (int n = 0; n < N_CYCLES; n++)
    begin
      tick();
      drive_random();
      check_lanes($sformatf("random_%0d", n));
    end
    if (i_flags_rename_top.i_flags_entry_buf.i_flags_rename_asserts.fail_count == 0)
    begin
      $display("Result: PASSED");
      $finish;
    end
    else
    begin
      fail_now();
    end
  end

endmodule

`default_nettype wire
